// File: f8_pkg.sv
/* Shared types for the cut-down f8 core.
   Widths, opcodes, flag layout, the structs passed between the core blocks
   and the instruction-size lookup used by fetch. */
package f8_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;
	// word index into one byte-wide bank
	typedef logic [14:0] bank_addr_t;

	typedef enum logic [7:0]
	{
		OPC_NOP = 8'h00,
		OPC_LD_XL_IMM = 8'h10,
		OPC_ADD_XL_IMM = 8'h11,
		OPC_SUB_XL_IMM = 8'h12,
		OPC_AND_XL_IMM = 8'h13,
		OPC_OR_XL_IMM = 8'h14,
		OPC_XOR_XL_IMM = 8'h15,
		OPC_LDW_Y_IMM = 8'h20,
		OPC_LD_DIR_XL = 8'h30,
		OPC_LDW_DIR_Y = 8'h31,
		OPC_JR = 8'h40,
		OPC_JRZ = 8'h41,
		OPC_JRNZ = 8'h42,
		OPC_JRC = 8'h43,
		OPC_TRAP = 8'hff
	} opcode_t;

	// c is bit 0, n bit 1, z bit 2
	typedef struct packed
	{
		logic z;
		logic n;
		logic c;
	} flags_t;

	// operand holds the bytes after the opcode, low byte first
	typedef struct packed
	{
		logic valid;
		addr_t pc;
		opcode_t opcode;
		word_t operand;
	} inst_t;

	typedef struct packed
	{
		logic halt;
		logic taken;
		addr_t target;
	} fetch_ctl_t;

	// en bit 0 is the low byte, bit 1 the high byte
	typedef struct packed
	{
		addr_t addr;
		word_t data;
		logic [1:0] en;
	} mem_wr_t;

	// unknown opcodes run as 1-byte nops
	function automatic logic [1:0] opcode_size(opcode_t opcode);
		case (opcode)
			OPC_LD_XL_IMM, OPC_ADD_XL_IMM, OPC_SUB_XL_IMM, OPC_AND_XL_IMM,
			OPC_OR_XL_IMM, OPC_XOR_XL_IMM, OPC_JR, OPC_JRZ, OPC_JRNZ, OPC_JRC:
				return 2'd2;
			OPC_LDW_Y_IMM, OPC_LD_DIR_XL, OPC_LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

// File: f8_alu.sv
/* 8-bit immediate ALU for the accumulator xl.
   Purely combinational; Z and N always follow the result. */
module f8_alu
	import f8_pkg::*;
(
	input opcode_t opcode,
	input byte_t acc,
	input byte_t imm,
	input flags_t flags_in,
	output byte_t result,
	output flags_t flags_out
);

	logic [8:0] sum;

	always_comb
	begin
		sum = '0;
		result = acc;
		flags_out = flags_in;
		case (opcode)
			OPC_ADD_XL_IMM:
			begin
				sum = {1'b0, acc} + {1'b0, imm};
				result = sum[7:0];
				flags_out.c = sum[8];
			end
			OPC_SUB_XL_IMM:
			begin
				// carry set means no borrow
				sum = {1'b0, acc} + {1'b0, ~imm} + 9'd1;
				result = sum[7:0];
				flags_out.c = sum[8];
			end
			OPC_AND_XL_IMM:
				result = acc & imm;
			OPC_OR_XL_IMM:
				result = acc | imm;
			OPC_XOR_XL_IMM:
				result = acc ^ imm;
			default:
				result = acc;
		endcase
		flags_out.z = result == 8'h00;
		flags_out.n = result[7];
	end

endmodule

// File: f8_fetch.sv
/* Instruction fetch. Holds pc, addresses the even and odd banks and
   assembles 1- to 3-byte instructions; 3-byte ones take a second read. */
module f8_fetch
	import f8_pkg::*;
#(
	parameter addr_t RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	input byte_t mem_read_data_even,
	input byte_t mem_read_data_odd,
	input fetch_ctl_t ctl,
	output bank_addr_t mem_read_addr_even,
	output bank_addr_t mem_read_addr_odd,
	output inst_t inst
);

	addr_t pc;
	addr_t next_pc;
	addr_t read_addr;
	logic upper_held;
	logic fetch_upper;
	word_t lower;
	byte_t byte0;
	byte_t byte1;
	logic [1:0] size;

	// byte at pc and pc+1, picked by pc parity
	assign byte0 = pc[0] ? mem_read_data_odd : mem_read_data_even;
	assign byte1 = pc[0] ? mem_read_data_even : mem_read_data_odd;

	always_comb
	begin
		if (upper_held)
		begin
			// pc+2 has the parity of pc, so the upper byte is byte0
			inst.opcode = opcode_t'(lower[7:0]);
			inst.operand = {byte0, lower[15:8]};
		end
		else
		begin
			inst.opcode = opcode_t'(byte0);
			inst.operand = {8'h00, byte1};
		end
		inst.pc = pc;
		size = opcode_size(inst.opcode);
		fetch_upper = !reset && size == 2'd3 && !upper_held;
		inst.valid = !reset && !fetch_upper;

		if (reset)
			next_pc = RESET_PC;
		else if (fetch_upper || ctl.halt)
			next_pc = pc;
		else if (ctl.taken)
			next_pc = ctl.target;
		else
			next_pc = pc + addr_t'(size);

		// taken branches go straight to the bank address, no bubble
		read_addr = fetch_upper ? pc + 16'd2 : next_pc;
	end

	// odd address: odd bank holds A, even bank holds A+1 one row up
	assign mem_read_addr_odd = read_addr[15:1];
	assign mem_read_addr_even = read_addr[15:1] + bank_addr_t'(read_addr[0]);

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
			upper_held <= 1'b0;
		else
			upper_held <= fetch_upper;
		if (fetch_upper)
			lower <= {byte1, byte0};
	end

endmodule

// File: f8_execute.sv
/* Execute stage. Decodes the assembled instruction, keeps xl, y and the
   flags, decides branches and raises store requests and trap. */
module f8_execute
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input inst_t inst,
	output fetch_ctl_t ctl,
	output mem_wr_t wr,
	output logic trap
);

	byte_t xl;
	byte_t next_xl;
	byte_t alu_result;
	word_t y;
	word_t next_y;
	flags_t flags;
	flags_t next_flags;
	flags_t alu_flags;
	addr_t rel_target;

	f8_alu i_alu
	(
		.opcode(inst.opcode),
		.acc(xl),
		.imm(inst.operand[7:0]),
		.flags_in(flags),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	// relative to the jump's own address
	assign rel_target = inst.pc + {{8{inst.operand[7]}}, inst.operand[7:0]};

	always_comb
	begin
		next_xl = xl;
		next_y = y;
		next_flags = flags;
		ctl = '0;
		ctl.target = rel_target;
		wr.addr = inst.operand;
		wr.data = (inst.opcode == OPC_LDW_DIR_Y) ? y : {8'h00, xl};
		wr.en = 2'b00;
		trap = 1'b0;

		if (inst.valid)
		begin
			case (inst.opcode)
				OPC_LD_XL_IMM:
					next_xl = inst.operand[7:0];
				OPC_ADD_XL_IMM, OPC_SUB_XL_IMM, OPC_AND_XL_IMM, OPC_OR_XL_IMM,
				OPC_XOR_XL_IMM:
				begin
					next_xl = alu_result;
					next_flags = alu_flags;
				end
				OPC_LDW_Y_IMM:
				begin
					next_y = inst.operand;
					next_flags.z = inst.operand == 16'h0000;
					next_flags.n = inst.operand[15];
				end
				OPC_LD_DIR_XL:
					wr.en = 2'b01;
				OPC_LDW_DIR_Y:
					wr.en = 2'b11;
				OPC_JR:
					ctl.taken = 1'b1;
				OPC_JRZ:
					ctl.taken = flags.z;
				OPC_JRNZ:
					ctl.taken = !flags.z;
				OPC_JRC:
					ctl.taken = flags.c;
				OPC_TRAP:
				begin
					// pc holds, so trap is seen again every cycle
					trap = 1'b1;
					ctl.halt = 1'b1;
				end
				default:
				begin
					// nop and unused opcodes change nothing
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			xl <= '0;
			y <= '0;
			flags <= '0;
		end
		else
		begin
			xl <= next_xl;
			y <= next_y;
			flags <= next_flags;
		end
	end

endmodule

// File: f8_mem_write.sv
/* Steers a byte or word store onto the even and odd banks.
   An odd address puts the low byte in the odd bank and the high byte one row up. */
module f8_mem_write
	import f8_pkg::*;
(
	input mem_wr_t wr,
	output bank_addr_t mem_write_addr_even,
	output bank_addr_t mem_write_addr_odd,
	output byte_t mem_write_data_even,
	output byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd
);

	logic odd;
	bank_addr_t index;

	assign odd = wr.addr[0];
	assign index = wr.addr[15:1];

	assign mem_write_addr_odd = index;
	assign mem_write_addr_even = index + bank_addr_t'(odd);

	// swap bytes and enables for odd addresses
	assign mem_write_data_even = odd ? wr.data[15:8] : wr.data[7:0];
	assign mem_write_data_odd = odd ? wr.data[7:0] : wr.data[15:8];
	assign mem_write_en_even = odd ? wr.en[1] : wr.en[0];
	assign mem_write_en_odd = odd ? wr.en[0] : wr.en[1];

endmodule

// File: f8_core.sv
/* Top level of the cut-down f8 core.
   Connects fetch, execute and store steering to the two memory banks. */
module f8_core
	import f8_pkg::*;
#(
	parameter addr_t RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	output bank_addr_t mem_read_addr_even,
	output bank_addr_t mem_read_addr_odd,
	input byte_t mem_read_data_even,
	input byte_t mem_read_data_odd,
	output bank_addr_t mem_write_addr_even,
	output bank_addr_t mem_write_addr_odd,
	output byte_t mem_write_data_even,
	output byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd,
	output logic trap
);

	inst_t inst;
	fetch_ctl_t ctl;
	mem_wr_t wr;

	f8_fetch #(.RESET_PC(RESET_PC)) i_fetch
	(
		.clk(clk),
		.reset(reset),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.ctl(ctl),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.inst(inst)
	);

	f8_execute i_execute
	(
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.ctl(ctl),
		.wr(wr),
		.trap(trap)
	);

	f8_mem_write i_mem_write
	(
		.wr(wr),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd)
	);

endmodule

// File: f8_chk.sv
/* Concurrent checks on the core's reset and trap behavior.
   Bound into every f8_core instance. */
module f8_chk
(
	input logic clk,
	input logic reset,
	input logic mem_write_en_even,
	input logic mem_write_en_odd,
	input logic trap
);

	int failures = 0;

	// core is quiet while held in reset
	reset_quiet: assert property (@(posedge clk)
		reset |-> !trap && !mem_write_en_even && !mem_write_en_odd)
		else
		begin
			$error("trap or a write enable high during reset");
			failures++;
		end

	// only a reset releases trap
	trap_sticky: assert property (@(posedge clk)
		trap |=> trap || reset)
		else
		begin
			$error("trap dropped without reset");
			failures++;
		end

	// halted core stores nothing until the next reset
	no_write_after_trap: assert property (@(posedge clk)
		trap |=> reset || (!mem_write_en_even && !mem_write_en_odd))
		else
		begin
			$error("write enable high after trap");
			failures++;
		end

endmodule

bind f8_core f8_chk i_chk
(
	.clk(clk),
	.reset(reset),
	.mem_write_en_even(mem_write_en_even),
	.mem_write_en_odd(mem_write_en_odd),
	.trap(trap)
);

// File: f8_tb.sv
/* Directed testbench for the f8 core. Models the even and odd banks,
   loads a program per test, runs it to TRAP and checks the logged stores. */
module f8_tb
	import f8_pkg::*;
;

	localparam addr_t RESET_PC = 16'h4000;
	localparam int CLK_PERIOD = 10;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 200;

	typedef struct packed
	{
		addr_t addr;
		byte_t data;
	} log_entry_t;

	logic clk;
	logic reset;
	bank_addr_t mem_read_addr_even;
	bank_addr_t mem_read_addr_odd;
	byte_t mem_read_data_even;
	byte_t mem_read_data_odd;
	bank_addr_t mem_write_addr_even;
	bank_addr_t mem_write_addr_odd;
	byte_t mem_write_data_even;
	byte_t mem_write_data_odd;
	logic mem_write_en_even;
	logic mem_write_en_odd;
	logic trap;

	byte_t bank_even [32768];
	byte_t bank_odd [32768];
	bank_addr_t read_even;
	bank_addr_t read_odd;
	log_entry_t even_entry;
	log_entry_t odd_entry;
	log_entry_t write_log [$];
	addr_t load_pc;
	int errors;
	int tests_passed;
	int tests_failed;

	f8_core #(.RESET_PC(RESET_PC)) i_dut
	(
		.clk(clk),
		.reset(reset),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd),
		.trap(trap)
	);

	always #(CLK_PERIOD / 2) clk = !clk;

	// bank model: writes and read address taken at the edge, data out 1 unit later
	always @(posedge clk)
	begin
		even_entry.addr = {mem_write_addr_even, 1'b0};
		even_entry.data = mem_write_data_even;
		odd_entry.addr = {mem_write_addr_odd, 1'b1};
		odd_entry.data = mem_write_data_odd;
		// log the lower byte address first
		if (mem_write_en_even && mem_write_en_odd && odd_entry.addr < even_entry.addr)
		begin
			write_log.push_back(odd_entry);
			write_log.push_back(even_entry);
		end
		else
		begin
			if (mem_write_en_even)
				write_log.push_back(even_entry);
			if (mem_write_en_odd)
				write_log.push_back(odd_entry);
		end
		if (mem_write_en_even)
			bank_even[mem_write_addr_even] = mem_write_data_even;
		if (mem_write_en_odd)
			bank_odd[mem_write_addr_odd] = mem_write_data_odd;
		read_even = mem_read_addr_even;
		read_odd = mem_read_addr_odd;
		#1;
		mem_read_data_even = bank_even[read_even];
		mem_read_data_odd = bank_odd[read_odd];
	end

	function automatic byte_t fill_byte(addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'ha5;
	endfunction

	function automatic byte_t alu_expect(opcode_t op, byte_t a, byte_t b);
		case (op)
			OPC_ADD_XL_IMM:
				return a + b;
			OPC_SUB_XL_IMM:
				return a - b;
			OPC_AND_XL_IMM:
				return a & b;
			OPC_OR_XL_IMM:
				return a | b;
			OPC_XOR_XL_IMM:
				return a ^ b;
			default:
				return a;
		endcase
	endfunction

	function automatic int writes_to(addr_t a);
		int count;
		count = 0;
		foreach (write_log[i])
			if (write_log[i].addr == a)
				count++;
		return count;
	endfunction

	// last byte logged at a, x when never written
	function automatic logic [7:0] value_at(addr_t a);
		logic [7:0] value;
		value = 8'hxx;
		foreach (write_log[i])
			if (write_log[i].addr == a)
				value = write_log[i].data;
		return value;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			errors++;
		end
	endtask

	task automatic clear_memory();
		int i;
		for (i = 0; i < 32768; i++)
		begin
			bank_even[i] = fill_byte({i[14:0], 1'b0});
			bank_odd[i] = fill_byte({i[14:0], 1'b1});
		end
		load_pc = RESET_PC;
	endtask

	task automatic emit_byte(input byte_t b);
		if (load_pc[0])
			bank_odd[load_pc[15:1]] = b;
		else
			bank_even[load_pc[15:1]] = b;
		load_pc++;
	endtask

	task automatic emit_imm8(input opcode_t op, input byte_t imm);
		emit_byte(op);
		emit_byte(imm);
	endtask

	task automatic emit_imm16(input opcode_t op, input word_t imm);
		emit_byte(op);
		emit_byte(imm[7:0]);
		emit_byte(imm[15:8]);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset = 1'b1;
		write_log.delete();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic wait_for_trap(input string name);
		int cycles;
		cycles = 0;
		while (trap !== 1'b1 && cycles < CYCLES_PER_TEST / 2)
		begin
			@(negedge clk);
			cycles++;
		end
		if (trap !== 1'b1)
		begin
			$display("%s: trap never rose within %0d cycles", name, CYCLES_PER_TEST / 2);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_byte_store();
		int errors_before;
		byte_t v;
		addr_t even_addr;
		addr_t odd_addr;
		errors_before = errors;
		v = 8'($urandom);
		even_addr = 16'($urandom) & 16'h3ffe;
		odd_addr = (16'($urandom) & 16'h3ffe) | 16'h0001;
		clear_memory();
		emit_imm8(OPC_LD_XL_IMM, v);
		emit_imm16(OPC_LD_DIR_XL, even_addr);
		emit_imm16(OPC_LD_DIR_XL, odd_addr);
		emit_byte(OPC_TRAP);
		apply_reset();
		wait_for_trap("byte_store");
		check_equal("byte store count", write_log.size(), 2);
		check_equal("byte at even address", value_at(even_addr), v);
		check_equal("byte at odd address", value_at(odd_addr), v);
		end_test("byte_store", errors_before);
	endtask

	task automatic test_alu();
		int errors_before;
		int k;
		opcode_t op;
		byte_t a [5];
		byte_t b [5];
		errors_before = errors;
		clear_memory();
		for (k = 0; k < 5; k++)
		begin
			// add, sub, and, or, xor are 0x11 to 0x15
			op = opcode_t'(8'h11 + k);
			a[k] = 8'($urandom);
			b[k] = 8'($urandom);
			emit_imm8(OPC_LD_XL_IMM, a[k]);
			emit_imm8(op, b[k]);
			emit_imm16(OPC_LD_DIR_XL, 16'h1000 + 16'(k));
		end
		emit_byte(OPC_TRAP);
		apply_reset();
		wait_for_trap("alu");
		check_equal("alu store count", write_log.size(), 5);
		for (k = 0; k < 5; k++)
		begin
			op = opcode_t'(8'h11 + k);
			check_equal($sformatf("alu result for %s", op.name()),
				value_at(16'h1000 + 16'(k)), alu_expect(op, a[k], b[k]));
		end
		end_test("alu", errors_before);
	endtask

	task automatic test_branch_flags();
		int errors_before;
		int i;
		opcode_t op;
		byte_t a;
		byte_t b;
		logic [8:0] sum;
		logic z;
		logic c;
		logic taken;
		logic [7:0] marker_expected;
		errors_before = errors;
		clear_memory();
		for (i = 0; i < 8; i++)
		begin
			op = i[0] ? OPC_SUB_XL_IMM : OPC_ADD_XL_IMM;
			a = 8'($urandom);
			b = 8'($urandom);
			// half the cases are forced to a zero result
			if (i[1])
				b = (op == OPC_SUB_XL_IMM) ? a : 8'(~a + 8'd1);
			if (op == OPC_ADD_XL_IMM)
			begin
				sum = 9'(a) + 9'(b);
				z = sum[7:0] == 8'h00;
				c = sum[8];
			end
			else
			begin
				z = a == b;
				c = a >= b;
			end
			case (i % 3)
				0:
					taken = z;
				1:
					taken = !z;
				default:
					taken = c;
			endcase
			marker_expected[i] = !taken;
			emit_imm8(OPC_LD_XL_IMM, a);
			emit_imm8(op, b);
			// skip the 3-byte marker store
			emit_imm8(opcode_t'(8'h41 + i % 3), 8'd5);
			emit_imm16(OPC_LD_DIR_XL, 16'h2000 + 16'(i));
		end
		emit_byte(OPC_TRAP);
		apply_reset();
		wait_for_trap("branch_flags");
		for (i = 0; i < 8; i++)
			check_equal($sformatf("branch case %0d marker stores", i),
				writes_to(16'h2000 + 16'(i)), marker_expected[i]);
		end_test("branch_flags", errors_before);
	endtask

	task automatic test_word_store();
		int errors_before;
		word_t w;
		addr_t even_addr;
		addr_t odd_addr;
		errors_before = errors;
		w = 16'($urandom);
		even_addr = 16'h1000 | (16'($urandom) & 16'h0ffe);
		odd_addr = 16'h2001 | (16'($urandom) & 16'h0ffe);
		clear_memory();
		emit_imm16(OPC_LDW_Y_IMM, w);
		emit_imm16(OPC_LDW_DIR_Y, even_addr);
		emit_imm16(OPC_LDW_DIR_Y, odd_addr);
		emit_byte(OPC_TRAP);
		apply_reset();
		wait_for_trap("word_store");
		check_equal("word store byte count", write_log.size(), 4);
		check_equal("even word low byte", value_at(even_addr), w[7:0]);
		check_equal("even word high byte", value_at(even_addr + 16'd1), w[15:8]);
		check_equal("odd word low byte", value_at(odd_addr), w[7:0]);
		check_equal("odd word high byte", value_at(odd_addr + 16'd1), w[15:8]);
		end_test("word_store", errors_before);
	endtask

	task automatic test_loop();
		int errors_before;
		int i;
		byte_t n;
		byte_t k;
		errors_before = errors;
		n = 8'd3 + 8'($urandom % 4);
		k = 8'($urandom);
		clear_memory();
		// 0x4000 load count, 0x4002 loop body, 0x400b exit
		emit_imm8(OPC_LD_XL_IMM, n);
		emit_imm16(OPC_LD_DIR_XL, 16'h3000);
		emit_imm8(OPC_SUB_XL_IMM, 8'd1);
		emit_imm8(OPC_JRZ, 8'd4);
		emit_imm8(OPC_JR, 8'hf9);
		emit_imm8(OPC_XOR_XL_IMM, k);
		emit_imm16(OPC_LD_DIR_XL, 16'h3001);
		emit_byte(OPC_TRAP);
		apply_reset();
		wait_for_trap("loop");
		check_equal("loop store count", write_log.size(), n + 1);
		if (write_log.size() == n + 1)
		begin
			for (i = 0; i < n; i++)
			begin
				check_equal($sformatf("loop pass %0d address", i), write_log[i].addr, 16'h3000);
				check_equal($sformatf("loop pass %0d value", i), write_log[i].data, n - i);
			end
			check_equal("loop exit address", write_log[n].addr, 16'h3001);
			check_equal("loop exit value", write_log[n].data, k);
		end
		end_test("loop", errors_before);
	endtask

	task automatic test_trap_reset();
		int errors_before;
		byte_t v;
		addr_t a;
		errors_before = errors;
		v = 8'($urandom) | 8'h01;
		a = 16'h1000 | (16'($urandom) & 16'h0fff);
		clear_memory();
		emit_imm8(OPC_LD_XL_IMM, v);
		emit_imm16(OPC_LD_DIR_XL, a);
		emit_byte(OPC_TRAP);
		// never reached
		emit_imm16(OPC_LD_DIR_XL, a ^ 16'h0100);
		apply_reset();
		wait_for_trap("trap_reset");
		write_log.delete();
		repeat (20)
		begin
			@(negedge clk);
			check_equal("trap held after TRAP", trap, 1);
		end
		check_equal("writes while trapped", write_log.size(), 0);
		apply_reset();
		@(negedge clk);
		check_equal("trap after new reset", trap, 0);
		wait_for_trap("trap_reset rerun");
		check_equal("store count after restart", write_log.size(), 1);
		check_equal("first store after restart", value_at(a), v);
		end_test("trap_reset", errors_before);
	endtask

	// budget covers every test at its full cycle allowance
	initial
	begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		mem_read_data_even = '0;
		mem_read_data_odd = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(96373));
		test_byte_store();
		test_alu();
		test_branch_flags();
		test_word_store();
		test_loop();
		test_trap_reset();
		check_equal("bound assertion failures", i_dut.i_chk.failures, 0);
		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: all.f
f8_pkg.sv
f8_alu.sv
f8_fetch.sv
f8_execute.sv
f8_mem_write.sv
f8_core.sv
f8_chk.sv
f8_tb.sv
